//--- src/sata_fifo_pkg.sv
// ========================================
// FIFO geometry, stored word and fill types
// fill thresholds for host and link flags
// ========================================
package sata_fifo_pkg;

    localparam int FIFO_ADDR_WIDTH = 9;                      // 512 entries per FIFO
    localparam int FIFO_DEPTH      = 1 << FIFO_ADDR_WIDTH;

    typedef logic [31:0] dword_t;                            // FIS payload dword
    typedef logic [1:0]  mask_t;                             // word mask, passed as is

    // memory words plus the output register, 0..513 fits in 10 bits
    typedef logic [FIFO_ADDR_WIDTH:0] fill_t;

    // 36-bit entry as stored in either FIFO
    typedef struct packed {
        logic [1:0] wtype;                                   // h2d or d2h type code
        mask_t      mask;
        dword_t     data;
    } fifo_word_t;

    // h2d_ready while fill <= FIFO_DEPTH - H2D_READY_ROOM
    localparam fill_t H2D_READY_ROOM = fill_t'(8);           // slack for words in flight

    localparam fill_t D2H_MANY_FILL = fill_t'(8);            // host may burst read

    // link gets told to pause from here on
    localparam fill_t D2H_ALMOST_FULL_FILL = fill_t'(448);

endpackage

//--- src/sata_fis_pkg.sv
// ========================================
// h2d / d2h word type codes, xmit threshold
// ========================================
package sata_fis_pkg;

    // word types written by the host
    typedef enum logic [1:0] {
        FIS_DATA = 2'd0,                     // dma data
        FIS_HEAD = 2'd1,                     // first dword of a FIS
        FIS_LAST = 2'd2                      // final dword of a FIS
    } h2d_type_e;

    // word types handed to the host
    typedef enum logic [1:0] {
        D2H_DATA = 2'd0,                     // FIS body
        D2H_HEAD = 2'd1,                     // first received dword
        D2H_OK   = 2'd2,                     // status word, frame good
        D2H_ERR  = 2'd3                      // status word, frame invalidated
    } d2h_type_e;

    // request a frame once this many dwords wait, even without FIS_LAST
    localparam int unsigned XMIT_START_FILL = 64;

endpackage

//--- src/fis_fifo.sv
// ========================================
// same-clock show-ahead FIFO, 512 x 36
// ========================================
module fis_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr,          // push wr_word
    input  sata_fifo_pkg::fifo_word_t wr_word,
    input  logic                      rd,          // pop head word
    output sata_fifo_pkg::fifo_word_t rd_word,     // head word, valid with out_valid
    output logic                      out_valid,
    output sata_fifo_pkg::fill_t      fill         // all stored words
);
    import sata_fifo_pkg::*;

    fifo_word_t               mem [FIFO_DEPTH];    // payload storage
    logic [FIFO_ADDR_WIDTH:0] wptr;                // extra msb tells full from empty
    logic [FIFO_ADDR_WIDTH:0] rptr;
    logic                     mem_nempty;          // words behind the output reg
    logic                     pop;
    logic                     load;                // refill output reg

    assign mem_nempty = (wptr != rptr);
    assign pop        = rd && out_valid;           // ignore pops of an empty head
    assign load       = mem_nempty && (!out_valid || pop);

    // memory write port
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wptr[FIFO_ADDR_WIDTH-1:0]] <= wr_word;
        end
    end

    // registered read into the show-ahead output
    always_ff @(posedge clk) begin
        if (load) begin
            rd_word <= mem[rptr[FIFO_ADDR_WIDTH-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr      <= '0;
            rptr      <= '0;
            out_valid <= 1'b0;
            fill      <= '0;
        end else begin
            if (wr) begin
                wptr <= wptr + 1'b1;
            end
            if (load) begin
                rptr <= rptr + 1'b1;
            end

            if (load) begin
                out_valid <= 1'b1;             // next word presented
            end else if (pop) begin
                out_valid <= 1'b0;             // popped the last one
            end

            // counts memory and output reg together
            fill <= fill + fill_t'(wr) - fill_t'(pop);
        end
    end

endmodule

//--- src/h2d_xmit_ctrl.sv
// ========================================
// h2d FIS pending flag and frame request
// ========================================
module h2d_xmit_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr,           // host writes a word
    input  sata_fis_pkg::h2d_type_e wr_type,
    input  sata_fifo_pkg::fill_t    fill,         // h2d FIFO fill
    input  logic                    frame_busy,   // link can't take a request now
    output logic                    frame_req     // one pulse per FIS
);
    import sata_fifo_pkg::*;
    import sata_fis_pkg::*;

    logic pending;                                // FIS started, not yet requested
    logic enough;                                 // whole FIS or a big chunk buffered
    logic req_now;

    assign enough = (wr && (wr_type == FIS_LAST)) ||
                    (fill >= fill_t'(XMIT_START_FILL));

    assign req_now = pending && !frame_busy && enough;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            frame_req <= 1'b0;
        end else begin
            frame_req <= req_now;
            // clear on the request edge so the next head can't retrigger it
            if (req_now) begin
                pending <= 1'b0;
            end else if (wr && (wr_type == FIS_HEAD)) begin
                pending <= 1'b1;
            end
        end
    end

endmodule

//--- src/d2h_fis_tagger.sv
// ========================================
// d2h word tagging, status word at frame end
// ========================================
module d2h_fis_tagger (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    word_valid,        // dword from the link
    input  logic                    incom_start,       // frame starts, 1 cycle
    input  logic                    incom_done,        // frame good, 1 cycle
    input  logic                    incom_invalidate,  // frame bad, 1 cycle
    output sata_fis_pkg::d2h_type_e tag,               // type of the word pushed now
    output logic                    push               // d2h FIFO write
);
    import sata_fis_pkg::*;

    logic frame_end;
    logic status_push;                                 // extra word after the frame

    assign frame_end = incom_done || incom_invalidate;

    // data words and the status word share the FIFO write
    assign push = word_valid || status_push;

    always_ff @(posedge clk) begin
        if (rst || incom_start) begin
            tag <= D2H_HEAD;                           // next word opens a FIS
        end else if (word_valid) begin
            tag <= D2H_DATA;
        end else if (frame_end) begin
            tag <= incom_invalidate ? D2H_ERR : D2H_OK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status_push <= 1'b0;
        end else begin
            // only after body data, so one status word per frame
            status_push <= frame_end && (tag == D2H_DATA);
        end
    end

endmodule

//--- src/sata_fis_buffers.sv
// ========================================
// h2d / d2h FIS buffers between host and link
// ========================================
module sata_fis_buffers (
    input  logic                    clk,
    input  logic                    rst,
    // host -> device, host side
    input  sata_fifo_pkg::dword_t   h2d_data,
    input  sata_fifo_pkg::mask_t    h2d_mask,
    input  sata_fis_pkg::h2d_type_e h2d_type,
    input  logic                    h2d_valid,            // write strobe
    output logic                    h2d_ready,            // room for more words
    // host -> device, link side
    output sata_fifo_pkg::dword_t   ll_h2d_data,
    output sata_fifo_pkg::mask_t    ll_h2d_mask,
    output logic                    ll_h2d_last,          // head word ends the FIS
    output logic                    ll_h2d_valid,
    input  logic                    ll_h2d_strobe,        // link takes the head word
    input  logic                    ll_frame_busy,
    output logic                    ll_frame_req,
    // device -> host, link side
    input  sata_fifo_pkg::dword_t   ll_d2h_data,
    input  sata_fifo_pkg::mask_t    ll_d2h_mask,
    input  logic                    ll_d2h_valid,
    input  logic                    ll_incom_start,
    input  logic                    ll_incom_done,
    input  logic                    ll_incom_invalidate,
    output logic                    ll_d2h_busy,          // almost full, pause link
    // device -> host, host side
    output sata_fifo_pkg::dword_t   d2h_data,
    output sata_fifo_pkg::mask_t    d2h_mask,
    output sata_fis_pkg::d2h_type_e d2h_type,
    output logic                    d2h_valid,
    output logic                    d2h_many,             // 8 or more words unread
    input  logic                    d2h_ready
);
    import sata_fifo_pkg::*;
    import sata_fis_pkg::*;

    fifo_word_t h2d_in;
    fifo_word_t h2d_out;
    fifo_word_t d2h_in;
    fifo_word_t d2h_out;
    fill_t      h2d_fill;
    fill_t      d2h_fill;
    logic       h2d_pop;
    logic       d2h_pop;
    logic       d2h_push;                                 // link word or status word
    d2h_type_e  d2h_tag;

    assign h2d_in.wtype = h2d_type;
    assign h2d_in.mask  = h2d_mask;
    assign h2d_in.data  = h2d_data;

    assign ll_h2d_data = h2d_out.data;
    assign ll_h2d_mask = h2d_out.mask;
    assign ll_h2d_last = (h2d_out.wtype == FIS_LAST);
    assign h2d_pop     = ll_h2d_strobe && ll_h2d_valid;
    assign h2d_ready   = (h2d_fill <= fill_t'(FIFO_DEPTH) - H2D_READY_ROOM);

    assign d2h_in.wtype = d2h_tag;                        // status payload is don't-care
    assign d2h_in.mask  = ll_d2h_mask;
    assign d2h_in.data  = ll_d2h_data;

    assign d2h_data    = d2h_out.data;
    assign d2h_mask    = d2h_out.mask;
    assign d2h_type    = d2h_type_e'(d2h_out.wtype);
    assign d2h_pop     = d2h_valid && d2h_ready;
    assign d2h_many    = (d2h_fill >= D2H_MANY_FILL);
    assign ll_d2h_busy = (d2h_fill >= D2H_ALMOST_FULL_FILL);

    fis_fifo u_h2d_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr        (h2d_valid),
        .wr_word   (h2d_in),
        .rd        (h2d_pop),
        .rd_word   (h2d_out),
        .out_valid (ll_h2d_valid),
        .fill      (h2d_fill)
    );

    fis_fifo u_d2h_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr        (d2h_push),
        .wr_word   (d2h_in),
        .rd        (d2h_pop),
        .rd_word   (d2h_out),
        .out_valid (d2h_valid),
        .fill      (d2h_fill)
    );

    h2d_xmit_ctrl u_xmit_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wr         (h2d_valid),
        .wr_type    (h2d_type),
        .fill       (h2d_fill),
        .frame_busy (ll_frame_busy),
        .frame_req  (ll_frame_req)
    );

    d2h_fis_tagger u_tagger (
        .clk              (clk),
        .rst              (rst),
        .word_valid       (ll_d2h_valid),
        .incom_start      (ll_incom_start),
        .incom_done       (ll_incom_done),
        .incom_invalidate (ll_incom_invalidate),
        .tag              (d2h_tag),
        .push             (d2h_push)
    );

endmodule

//--- dv/tb_sata_fis_buffers.sv
// ========================================
// testbench for sata_fis_buffers, link and host models
// ========================================
module tb_sata_fis_buffers;
    timeunit 1ns;
    timeprecision 1ps;
    import sata_fifo_pkg::*;
    import sata_fis_pkg::*;

    localparam int MAX_RECS   = 32;
    localparam int WAIT_LIMIT = 2000;                  // cycles per wait loop

    logic      clk, rst, h2d_valid, h2d_ready, ll_h2d_last, ll_h2d_valid, ll_h2d_strobe;
    logic      ll_frame_busy, ll_frame_req, ll_d2h_valid, ll_incom_start, ll_incom_done;
    logic      ll_incom_invalidate, ll_d2h_busy, d2h_valid, d2h_many, d2h_ready;
    dword_t    h2d_data, ll_h2d_data, ll_d2h_data, d2h_data;
    mask_t     h2d_mask, ll_h2d_mask, ll_d2h_mask, d2h_mask;
    h2d_type_e h2d_type;
    d2h_type_e d2h_type;

    logic [47:0] pats [MAX_RECS];                      // op, count, hold, seed offset, end type
    int          err_cnt, timeout_cnt, seed, req_cnt, req_words, wr_cnt;
    dword_t      h2d_exp_data [$];                     // words the link should see
    mask_t       h2d_exp_mask [$];
    h2d_type_e   h2d_exp_type [$];
    dword_t      d2h_exp_data [$];                     // words the host should see
    d2h_type_e   d2h_exp_type [$];

    sata_fis_buffers uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                        // 20 ns period
    end

    task automatic report_fail(string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic report_timeout(string what);
        $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        timeout_cnt++;
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected)
            report_fail($sformatf("%s is %b, expected %b", name, actual, expected));
    endtask

    task automatic check_h2d_word(dword_t exp_data, mask_t exp_mask, h2d_type_e exp_type);
        if (ll_h2d_data !== exp_data || ll_h2d_mask !== exp_mask ||
            ll_h2d_last !== (exp_type == FIS_LAST))
            report_fail($sformatf("h2d word %h mask %0d last %b, expected %h mask %0d %s",
                ll_h2d_data, ll_h2d_mask, ll_h2d_last, exp_data, exp_mask, exp_type.name()));
    endtask

    task automatic check_d2h_word(dword_t exp_data, d2h_type_e exp_type);
        // status word payload is don't-care
        if (d2h_type !== exp_type ||
            ((exp_type == D2H_HEAD || exp_type == D2H_DATA) &&
             (d2h_data !== exp_data || d2h_mask !== exp_data[1:0])))
            report_fail($sformatf("d2h word %h mask %0d %s, expected %h mask %0d %s",
                d2h_data, d2h_mask, d2h_type.name(),
                exp_data, exp_data[1:0], exp_type.name()));
    endtask

    // one cycle, sample at the falling edge before anything is driven
    task automatic tick();
        @(negedge clk);
        if (ll_frame_req) begin
            req_cnt++;
            req_words = wr_cnt;
            if (ll_frame_busy)
                report_fail("ll_frame_req raised while ll_frame_busy was high");
        end
    endtask

    task automatic run_h2d(int count, int hold, h2d_type_e last_type);
        int     busy_left;
        int     guard;
        dword_t w;
        busy_left     = hold;
        req_cnt       = 0;
        wr_cnt        = 0;
        ll_frame_busy = (busy_left > 0);
        for (int k = 0; k < count; k++) begin
            tick();
            if (busy_left > 0) busy_left--;
            ll_frame_busy = (busy_left > 0);
            check_flag("h2d_ready", h2d_ready, 1'b1);
            w         = dword_t'($random(seed));
            h2d_data  = w;
            h2d_mask  = mask_t'(k);
            h2d_type  = (k == 0) ? FIS_HEAD : ((k == count - 1) ? last_type : FIS_DATA);
            h2d_valid = 1'b1;
            h2d_exp_data.push_back(w);
            h2d_exp_mask.push_back(mask_t'(k));
            h2d_exp_type.push_back(h2d_type);
            wr_cnt++;
        end
        tick();                                        // last word written by now
        h2d_valid = 1'b0;
        if (busy_left > 0) busy_left--;
        ll_frame_busy = (busy_left > 0);
        guard = 0;
        while (req_cnt == 0 && guard < WAIT_LIMIT) begin  // busy hold runs out here
            tick();
            if (busy_left > 0) busy_left--;
            ll_frame_busy = (busy_left > 0);
            guard++;
        end
        if (req_cnt == 0) report_timeout("ll_frame_req");
        if (count > XMIT_START_FILL && hold == 0)
            check_flag("request before FIS_LAST", req_words < count, 1'b1);
        guard = 0;
        while (h2d_exp_data.size() > 0 && guard < WAIT_LIMIT) begin
            tick();
            ll_h2d_strobe = ll_h2d_valid;              // link takes every presented word
            if (ll_h2d_valid) begin
                check_h2d_word(h2d_exp_data[0], h2d_exp_mask[0], h2d_exp_type[0]);
                void'(h2d_exp_data.pop_front());
                void'(h2d_exp_mask.pop_front());
                void'(h2d_exp_type.pop_front());
            end
            guard++;
        end
        if (h2d_exp_data.size() > 0) report_timeout("h2d words on the link side");
        repeat (4) tick();                             // catch a late second pulse
        ll_h2d_strobe = 1'b0;
        check_flag("single ll_frame_req pulse", req_cnt == 1, 1'b1);
        check_flag("ll_h2d_valid after drain", ll_h2d_valid, 1'b0);
    endtask

    task automatic run_d2h(int count, bit stall, bit invalid, d2h_type_e end_type);
        int     step;
        int     held;                                  // d2h fill after the next edge
        int     guard;
        dword_t w;
        step  = 0;
        held  = 0;
        guard = 0;
        while ((step <= count + 2 || d2h_exp_type.size() > 0) && guard < WAIT_LIMIT) begin
            tick();
            check_flag("d2h_many", d2h_many, held >= 8);
            check_flag("ll_d2h_busy", ll_d2h_busy, held >= 448);
            if (d2h_valid && d2h_exp_type.size() == 0)
                report_fail("d2h word presented with none expected");
            else if (d2h_valid)
                check_d2h_word(d2h_exp_data[0], d2h_exp_type[0]);
            d2h_ready = !(stall && step <= count + 2);  // host holds off in stall mode
            if (d2h_valid && d2h_ready && d2h_exp_type.size() > 0) begin
                void'(d2h_exp_data.pop_front());
                void'(d2h_exp_type.pop_front());
                held--;
            end
            ll_incom_start      = (step == 0);
            ll_d2h_valid        = (step >= 1 && step <= count);
            ll_incom_done       = (step == count + 1) && !invalid;
            ll_incom_invalidate = (step == count + 1) && invalid;
            if (ll_d2h_valid) begin
                w           = dword_t'($random(seed));
                ll_d2h_data = w;
                ll_d2h_mask = w[1:0];
                d2h_exp_data.push_back(w);
                d2h_exp_type.push_back((step == 1) ? D2H_HEAD : D2H_DATA);
                held++;
            end
            if (step == count + 2) begin               // status word lands on the next edge
                d2h_exp_data.push_back('0);
                d2h_exp_type.push_back(end_type);
                held++;
            end
            step++;
            guard++;
        end
        if (guard >= WAIT_LIMIT) report_timeout("d2h words on the host side");
        tick();
        check_flag("d2h_valid after drain", d2h_valid, 1'b0);
    endtask

    initial begin
        int          idx;
        logic [47:0] rec;
        {rst, h2d_valid, ll_h2d_strobe, ll_frame_busy, ll_d2h_valid} = 5'b10000;
        {ll_incom_start, ll_incom_done, ll_incom_invalidate, d2h_ready} = 4'b0000;
        h2d_data    = '0;
        h2d_mask    = '0;
        h2d_type    = FIS_DATA;
        ll_d2h_data = '0;
        ll_d2h_mask = '0;
        err_cnt     = 0;
        timeout_cnt = 0;
        seed        = 36;
        req_cnt     = 0;
        req_words   = 0;
        wr_cnt      = 0;
        for (idx = 0; idx < MAX_RECS; idx++) pats[idx] = '0;  // list ends at op 00
        $readmemh("dv/fis_patterns.txt", pats);
        repeat (2) @(negedge clk);
        rst = 1'b0;
        tick();
        check_flag("ll_frame_req", ll_frame_req, 1'b0);
        check_flag("ll_h2d_valid", ll_h2d_valid, 1'b0);
        check_flag("d2h_valid", d2h_valid, 1'b0);
        check_flag("d2h_many", d2h_many, 1'b0);
        check_flag("ll_d2h_busy", ll_d2h_busy, 1'b0);
        check_flag("h2d_ready", h2d_ready, 1'b1);
        if (pats[0][47:40] == 8'h00) begin
            $display("No records found in the pattern file");
            err_cnt++;
        end
        idx = 0;
        while (idx < MAX_RECS && pats[idx][47:40] != 8'h00) begin
            rec  = pats[idx];
            seed = 36 + int'(rec[15:8]);               // per-record payload stream
            case (rec[47:40])
                8'h01:   run_h2d(int'(rec[39:24]), int'(rec[23:16]), h2d_type_e'(rec[1:0]));
                8'h02:   run_d2h(int'(rec[39:24]), 1'b0, 1'b0, d2h_type_e'(rec[1:0]));
                8'h03:   run_d2h(int'(rec[39:24]), 1'b0, 1'b1, d2h_type_e'(rec[1:0]));
                8'h04:   run_d2h(int'(rec[39:24]), 1'b1, 1'b0, d2h_type_e'(rec[1:0]));
                default: begin
                    $display("Unknown op code %h in pattern record %0d", rec[47:40], idx);
                    err_cnt++;
                end
            endcase
            idx++;
        end
        $display("Errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- dv/fis_patterns.txt
// columns: op_count_hold_seedoffset_endtype, op 01 h2d, 02 d2h, 03 d2h invalidated, 04 d2h host stall
// count in dwords, hold in cycles of ll_frame_busy, endtype of the closing word (LAST/OK = 2, ERR = 3)

// short h2d FIS, request on FIS_LAST
01_0002_00_00_02
01_0005_00_01_02
01_0011_00_02_02
01_003f_00_03_02

// long h2d FIS, request once 64 dwords wait
01_0050_00_04_02
01_0064_00_05_02

// long h2d FIS with the link busy past the last write
01_0050_96_06_02
01_0048_c8_07_02

// d2h FIS closed by done
02_0001_00_08_02
02_0004_00_09_02
02_0020_00_0a_02

// d2h FIS closed by invalidate
03_0003_00_0b_03
03_0010_00_0c_03

// d2h FIS with the host holding off until the frame is stored
04_0007_00_0d_02
04_01cc_00_0e_02

// short h2d FIS after the big d2h one
01_0003_00_0f_02

// end of list
00_0000_00_00_00

//--- vlog.f
src/sata_fifo_pkg.sv
src/sata_fis_pkg.sv
src/fis_fifo.sv
src/h2d_xmit_ctrl.sv
src/d2h_fis_tagger.sv
src/sata_fis_buffers.sv
dv/tb_sata_fis_buffers.sv

//--- run_sim.sh
#!/bin/sh
# build the FIS buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_sata_fis_buffers -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
